//--- logic/pwrCtrlPkg.sv
// Shared constants and FSM state type; numDomains above 32 would not fit the register word
package pwrCtrlPkg;

  // ------------------------------
  // Domain and sequencing sizes
  // ------------------------------

  // Number of switchable power domains
  localparam int numDomains = 2;

  // Cycles spent in settle after power switch 2 turns on
  localparam int settleCycles = 28;

  // Settle counter width and its terminal value
  localparam int settleCntWidth = $clog2(settleCycles);
  localparam logic [settleCntWidth-1:0] settleLast = settleCntWidth'(settleCycles - 1);

  // ------------------------------
  // Register map and AXI codes
  // ------------------------------

  // Byte offsets on the 4 bit AXI4-Lite address
  localparam logic [3:0] addrCtrl   = 4'h0;
  localparam logic [3:0] addrStatus = 4'h4;

  // AXI response encodings
  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  // ------------------------------
  // Sequencer states
  // ------------------------------

  // Power-down runs idle to pwrOff, power-up runs pwrOn1 to rstClear
  typedef enum logic [3:0] {
    idle,
    clkOff,
    clkWait,
    isolate,
    save,
    prePwrOff,
    pwrOff,
    pwrOn1,
    settle,
    restore,
    restoreWait,
    deIsolate,
    clkOn,
    clkOnWait,
    rstClear
  } seqState;

endpackage

//--- logic/pwrSeqFsm.sv
// One domain only; a request cleared during power-down is seen only once pwrOff is reached
module pwrSeqFsm (
  input  logic pclk14,
  input  logic nprst14,
  input  logic lowPowerReq,
  output logic setStatus,
  output logic clrStatus,
  output logic gateClk,
  output logic isolate,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On,
  output logic rstnNonRet
);

  // State register and next state
  pwrCtrlPkg::seqState currState;
  pwrCtrlPkg::seqState nextState;

  // Settle counter, runs only while in settle
  logic [pwrCtrlPkg::settleCntWidth-1:0] settleCnt;

  // Registered non-retention reset level before the combine with nprst14
  logic rstnNonRetReg;

  // ------------------------------
  // Next state logic
  // ------------------------------

  always_comb
  begin
    nextState = currState;
    case (currState)
      // Wait for software to request shut-off
      pwrCtrlPkg::idle:
        if (lowPowerReq)
        begin
          nextState = pwrCtrlPkg::clkOff;
        end
      pwrCtrlPkg::clkOff:
        nextState = pwrCtrlPkg::clkWait;
      // One spare cycle for the clock gate to take hold
      pwrCtrlPkg::clkWait:
        nextState = pwrCtrlPkg::isolate;
      pwrCtrlPkg::isolate:
        nextState = pwrCtrlPkg::save;
      pwrCtrlPkg::save:
        nextState = pwrCtrlPkg::prePwrOff;
      pwrCtrlPkg::prePwrOff:
        nextState = pwrCtrlPkg::pwrOff;
      // Stay off until the request bit is cleared
      pwrCtrlPkg::pwrOff:
        if (!lowPowerReq)
        begin
          nextState = pwrCtrlPkg::pwrOn1;
        end
      pwrCtrlPkg::pwrOn1:
        nextState = pwrCtrlPkg::settle;
      // Let the supply settle before restoring state
      pwrCtrlPkg::settle:
        if (settleCnt == pwrCtrlPkg::settleLast)
        begin
          nextState = pwrCtrlPkg::restore;
        end
      pwrCtrlPkg::restore:
        nextState = pwrCtrlPkg::restoreWait;
      pwrCtrlPkg::restoreWait:
        nextState = pwrCtrlPkg::deIsolate;
      pwrCtrlPkg::deIsolate:
        nextState = pwrCtrlPkg::clkOn;
      pwrCtrlPkg::clkOn:
        nextState = pwrCtrlPkg::clkOnWait;
      // Clock running again before the reset lifts
      pwrCtrlPkg::clkOnWait:
        nextState = pwrCtrlPkg::rstClear;
      pwrCtrlPkg::rstClear:
        nextState = pwrCtrlPkg::idle;
      // Unused encoding falls back to idle
      default:
        nextState = pwrCtrlPkg::idle;
    endcase
  end

  // State register
  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      currState <= pwrCtrlPkg::idle;
    end
    else
    begin
      currState <= nextState;
    end
  end

  // Counter held at zero outside settle
  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      settleCnt <= '0;
    end
    else if (currState == pwrCtrlPkg::settle)
    begin
      settleCnt <= settleCnt + 1'b1;
    end
    else
    begin
      settleCnt <= '0;
    end
  end

  // ------------------------------
  // Registered control outputs
  // ------------------------------

  // Decoded from nextState so each output moves with its state
  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      gateClk       <= 1'b0;
      isolate       <= 1'b0;
      saveEdge      <= 1'b0;
      restoreEdge   <= 1'b0;
      pwr1On        <= 1'b1;
      pwr2On        <= 1'b1;
      rstnNonRetReg <= 1'b0;
    end
    else
    begin
      // Clock gated from clkOff through deIsolate
      gateClk <= !(nextState inside {pwrCtrlPkg::idle, pwrCtrlPkg::clkOn,
                                     pwrCtrlPkg::clkOnWait, pwrCtrlPkg::rstClear});
      // Isolation covers the whole unpowered window
      isolate <= nextState inside {pwrCtrlPkg::isolate, pwrCtrlPkg::save,
                                   pwrCtrlPkg::prePwrOff, pwrCtrlPkg::pwrOff,
                                   pwrCtrlPkg::pwrOn1, pwrCtrlPkg::settle,
                                   pwrCtrlPkg::restore, pwrCtrlPkg::restoreWait};
      saveEdge    <= (nextState == pwrCtrlPkg::save);
      restoreEdge <= (nextState == pwrCtrlPkg::restore);
      // Switch 1 returns one state ahead of switch 2
      pwr1On <= (nextState != pwrCtrlPkg::pwrOff);
      pwr2On <= !(nextState inside {pwrCtrlPkg::pwrOff, pwrCtrlPkg::pwrOn1});
      // Non-retention flops held in reset from pwrOff until rstClear
      rstnNonRetReg <= nextState inside {pwrCtrlPkg::idle, pwrCtrlPkg::clkOff,
                                         pwrCtrlPkg::clkWait, pwrCtrlPkg::isolate,
                                         pwrCtrlPkg::save, pwrCtrlPkg::prePwrOff,
                                         pwrCtrlPkg::rstClear};
    end
  end

  // ------------------------------
  // Status pulses and reset combine
  // ------------------------------

  // Set on leaving idle, clear on the last power-up state
  assign setStatus = (nextState == pwrCtrlPkg::clkOff);
  assign clrStatus = (currState == pwrCtrlPkg::rstClear);

  // Chip reset also resets the non-retention flops
  assign rstnNonRet = rstnNonRetReg & nprst14;

endmodule

//--- logic/pwrRegsAxil.sv
// One outstanding access per side; write strobes ignored and only full words are written
module pwrRegsAxil (
  input  logic                              pclk14,
  input  logic                              nprst14,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [3:0]                        awaddr,
  input  logic                              wvalid,
  output logic                              wready,
  input  logic [31:0]                       wdata,
  output logic                              bvalid,
  input  logic                              bready,
  output logic [1:0]                        bresp,
  input  logic                              arvalid,
  output logic                              arready,
  input  logic [3:0]                        araddr,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [31:0]                       rdata,
  output logic [1:0]                        rresp,
  input  logic [pwrCtrlPkg::numDomains-1:0] setStatus,
  input  logic [pwrCtrlPkg::numDomains-1:0] clrStatus,
  output logic [pwrCtrlPkg::numDomains-1:0] lowPowerReq
);

  // Request and status registers
  logic [pwrCtrlPkg::numDomains-1:0] ctrlReg;
  logic [pwrCtrlPkg::numDomains-1:0] statusReg;

  // Shared ready for address and data of a write
  logic wrReady;
  logic wrAccept;
  logic wrHs;
  logic arAccept;
  logic rdHs;

  // ------------------------------
  // Write channel
  // ------------------------------

  // Ready only with both valids up and no response waiting
  assign wrAccept = awvalid && wvalid && !bvalid && !wrReady;
  assign wrHs     = wrReady && awvalid && wvalid;
  assign awready  = wrReady;
  assign wready   = wrReady;

  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      wrReady <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= pwrCtrlPkg::respOkay;
      ctrlReg <= '0;
    end
    else
    begin
      wrReady <= wrAccept;
      if (wrHs)
      begin
        bvalid <= 1'b1;
        // Only the control word is writable
        if (awaddr == pwrCtrlPkg::addrCtrl)
        begin
          ctrlReg <= wdata[pwrCtrlPkg::numDomains-1:0];
          bresp   <= pwrCtrlPkg::respOkay;
        end
        else
        begin
          bresp <= pwrCtrlPkg::respSlvErr;
        end
      end
      // Response held until the master takes it
      else if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Read channel
  // ------------------------------

  assign arAccept = arvalid && !rvalid && !arready;
  assign rdHs     = arready && arvalid;

  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rresp   <= pwrCtrlPkg::respOkay;
    end
    else
    begin
      arready <= arAccept;
      if (rdHs)
      begin
        rvalid <= 1'b1;
        case (araddr)
          pwrCtrlPkg::addrCtrl:
          begin
            rdata <= {{(32 - pwrCtrlPkg::numDomains){1'b0}}, ctrlReg};
            rresp <= pwrCtrlPkg::respOkay;
          end
          pwrCtrlPkg::addrStatus:
          begin
            rdata <= {{(32 - pwrCtrlPkg::numDomains){1'b0}}, statusReg};
            rresp <= pwrCtrlPkg::respOkay;
          end
          // Unmapped offset reads as zero with an error
          default:
          begin
            rdata <= '0;
            rresp <= pwrCtrlPkg::respSlvErr;
          end
        endcase
      end
      else if (rvalid && rready)
      begin
        rvalid <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Status bits from the sequencers
  // ------------------------------

  // Set and clear pulses never coincide for one domain
  always_ff @(posedge pclk14 or negedge nprst14)
  begin
    if (!nprst14)
    begin
      statusReg <= '0;
    end
    else
    begin
      statusReg <= (statusReg | setStatus) & ~clrStatus;
    end
  end

  // Requests go straight to the sequencers
  assign lowPowerReq = ctrlReg;

endmodule

//--- logic/pwrCtrlTop.sv
// Control outputs are plain levels; no clock-gate or power-switch cells are included here
module pwrCtrlTop (
  input  logic                              pclk14,
  input  logic                              nprst14,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [3:0]                        awaddr,
  input  logic                              wvalid,
  output logic                              wready,
  input  logic [31:0]                       wdata,
  output logic                              bvalid,
  input  logic                              bready,
  output logic [1:0]                        bresp,
  input  logic                              arvalid,
  output logic                              arready,
  input  logic [3:0]                        araddr,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [31:0]                       rdata,
  output logic [1:0]                        rresp,
  output logic [pwrCtrlPkg::numDomains-1:0] gateClk,
  output logic [pwrCtrlPkg::numDomains-1:0] isolate,
  output logic [pwrCtrlPkg::numDomains-1:0] saveEdge,
  output logic [pwrCtrlPkg::numDomains-1:0] restoreEdge,
  output logic [pwrCtrlPkg::numDomains-1:0] pwr1On,
  output logic [pwrCtrlPkg::numDomains-1:0] pwr2On,
  output logic [pwrCtrlPkg::numDomains-1:0] rstnNonRet
);

  // Per-domain links between register slave and sequencers
  logic [pwrCtrlPkg::numDomains-1:0] lowPowerReq;
  logic [pwrCtrlPkg::numDomains-1:0] setStatus;
  logic [pwrCtrlPkg::numDomains-1:0] clrStatus;

  // ------------------------------
  // Register slave
  // ------------------------------

  pwrRegsAxil pwrRegsAxil_inst (
    .pclk14      (pclk14),
    .nprst14     (nprst14),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .rresp       (rresp),
    .setStatus   (setStatus),
    .clrStatus   (clrStatus),
    .lowPowerReq (lowPowerReq)
  );

  // ------------------------------
  // One sequencer per domain
  // ------------------------------

  for (genvar d = 0; d < pwrCtrlPkg::numDomains; d++)
  begin : genDomain
    pwrSeqFsm pwrSeqFsm_inst (
      .pclk14      (pclk14),
      .nprst14     (nprst14),
      .lowPowerReq (lowPowerReq[d]),
      .setStatus   (setStatus[d]),
      .clrStatus   (clrStatus[d]),
      .gateClk     (gateClk[d]),
      .isolate     (isolate[d]),
      .saveEdge    (saveEdge[d]),
      .restoreEdge (restoreEdge[d]),
      .pwr1On      (pwr1On[d]),
      .pwr2On      (pwr2On[d]),
      .rstnNonRet  (rstnNonRet[d])
    );
  end

endmodule

//--- sim/pwrSeq_sva.sv
// Bound into every pwrSeqFsm; all checks are off while nprst14 is low
module pwrSeqSva (
  input logic                pclk14,
  input logic                nprst14,
  input logic                setStatus,
  input logic                clrStatus,
  input logic                gateClk,
  input logic                isolate,
  input logic                pwr1On,
  input logic                pwr2On,
  input pwrCtrlPkg::seqState currState
);

  // ------------------------------
  // Sequencer output order
  // ------------------------------

  // Status pulses come from different states
  statusExclusive: assert property (@(posedge pclk14) disable iff (!nprst14)
    !(setStatus && clrStatus))
    else $error("setStatus and clrStatus high together");

  // Clock gate first, isolation two edges later
  gateThenIsolate: assert property (@(posedge pclk14) disable iff (!nprst14)
    $rose(gateClk) |-> ##2 $rose(isolate))
    else $error("isolate did not rise two edges after gateClk");

  // Both switches open on the same edge
  switchesOffTogether: assert property (@(posedge pclk14) disable iff (!nprst14)
    $fell(pwr1On) |-> $fell(pwr2On))
    else $error("pwr1On and pwr2On did not fall together");

  // Switch 2 closes one edge after switch 1
  switch2Follows: assert property (@(posedge pclk14) disable iff (!nprst14)
    $rose(pwr1On) |=> pwr2On)
    else $error("pwr2On not high one edge after pwr1On rose");

  // Unpowered outputs stay clamped
  isolatedWhenOff: assert property (@(posedge pclk14) disable iff (!nprst14)
    !pwr1On |-> isolate && currState == pwrCtrlPkg::pwrOff)
    else $error("pwr1On low outside pwrOff or without isolation");

endmodule

bind pwrSeqFsm pwrSeqSva pwrSeqSva_inst (
  .pclk14    (pclk14),
  .nprst14   (nprst14),
  .setStatus (setStatus),
  .clrStatus (clrStatus),
  .gateClk   (gateClk),
  .isolate   (isolate),
  .pwr1On    (pwr1On),
  .pwr2On    (pwr2On),
  .currState (currState)
);

//--- sim/pwrCtrlTb.sv
// Directed tests for pwrCtrlTop; the run stops at the first failed check or at the watchdog limit
module pwrCtrlTb;

  localparam int nd = pwrCtrlPkg::numDomains;
  // Budget of 12 full sequences plus AXI margin, in clock cycles
  localparam int watchdogCycles = 12 * (30 + pwrCtrlPkg::settleCycles) + 200;

  logic pclk14;
  logic nprst14;
  logic awvalid;
  logic awready;
  logic [3:0] awaddr;
  logic wvalid;
  logic wready;
  logic [31:0] wdata;
  logic bvalid;
  logic bready;
  logic [1:0] bresp;
  logic arvalid;
  logic arready;
  logic [3:0] araddr;
  logic rvalid;
  logic rready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic [nd-1:0] gateClk;
  logic [nd-1:0] isolate;
  logic [nd-1:0] saveEdge;
  logic [nd-1:0] restoreEdge;
  logic [nd-1:0] pwr1On;
  logic [nd-1:0] pwr2On;
  logic [nd-1:0] rstnNonRet;

  // Reference model of the request register and expected pulse counts
  logic [nd-1:0] ctrlModel;
  int expSave [nd];
  int expRestore [nd];
  int saveCnt [nd];
  int restoreCnt [nd];
  integer seed;

  pwrCtrlTop pwrCtrlTop_inst (.*);

  initial
  begin
    pclk14 = 1'b0;
    forever #2 pclk14 = ~pclk14;
  end

  // Pulses are one cycle wide, so a high sample at negedge is one pulse
  always @(negedge pclk14)
  begin
    for (int d = 0; d < nd; d++)
    begin
      if (saveEdge[d])
        saveCnt[d]++;
      if (restoreEdge[d])
        restoreCnt[d]++;
    end
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge pclk14);
    $display("Timeout: sequence did not finish");
    $display("TB FAILED");
    $fatal(1);
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic checkValue(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    assert (actVal === expVal)
    else
    begin
      $display("** Error @ %0t: %s expected %h, got %h", $time, what, expVal, actVal);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  function automatic int randBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Called at a negedge; handshake happens on the edge after awready is seen
  task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                          input logic [1:0] expResp, input int delay);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge pclk14);
    while (!awready)
      @(negedge pclk14);
    // Address and data are taken together
    checkValue("wready", 1, wready);
    @(negedge pclk14);
    awvalid = 1'b0;
    wvalid = 1'b0;
    // Response must hold through the bready stall
    repeat (delay) @(negedge pclk14);
    checkValue("bvalid", 1, bvalid);
    checkValue("bresp", expResp, bresp);
    bready = 1'b1;
    @(negedge pclk14);
    bready = 1'b0;
    checkValue("bvalid after accept", 0, bvalid);
  endtask

  task automatic axiRead(input logic [3:0] addr, input logic [1:0] expResp,
                         input int delay, output logic [31:0] data);
    araddr = addr;
    arvalid = 1'b1;
    @(negedge pclk14);
    while (!arready)
      @(negedge pclk14);
    @(negedge pclk14);
    arvalid = 1'b0;
    repeat (delay) @(negedge pclk14);
    checkValue("rvalid", 1, rvalid);
    checkValue("rresp", expResp, rresp);
    data = rdata;
    rready = 1'b1;
    @(negedge pclk14);
    rready = 0;
    checkValue("rvalid after accept", 0, rvalid);
  endtask

  task automatic pollStatus(input logic [nd-1:0] expStatus);
    logic [31:0] data;
    data = '1;
    while (data !== 32'(expStatus))
      axiRead(pwrCtrlPkg::addrStatus, pwrCtrlPkg::respOkay, 0, data);
  endtask

  // Status sets early, so wait for the switches to drop as well
  task automatic waitDown(input logic [nd-1:0] pattern);
    for (int d = 0; d < nd; d++)
    begin
      while (pattern[d] && pwr1On[d] !== 1'b0)
        @(negedge pclk14);
    end
  endtask

  task automatic checkDomain(input int d, input logic down);
    checkValue($sformatf("pwr1On[%0d]", d), !down, pwr1On[d]);
    checkValue($sformatf("pwr2On[%0d]", d), !down, pwr2On[d]);
    checkValue($sformatf("isolate[%0d]", d), down, isolate[d]);
    checkValue($sformatf("gateClk[%0d]", d), down, gateClk[d]);
    checkValue($sformatf("rstnNonRet[%0d]", d), !down, rstnNonRet[d]);
  endtask

  task automatic checkCounts;
    for (int d = 0; d < nd; d++)
    begin
      checkValue($sformatf("save count[%0d]", d), expSave[d], saveCnt[d]);
      checkValue($sformatf("restore count[%0d]", d), expRestore[d], restoreCnt[d]);
    end
  endtask

  // Each rising request bit costs one save, each falling one a restore
  task automatic writeRequest(input logic [nd-1:0] newCtrl);
    for (int d = 0; d < nd; d++)
    begin
      if (newCtrl[d] && !ctrlModel[d])
        expSave[d]++;
      if (!newCtrl[d] && ctrlModel[d])
        expRestore[d]++;
    end
    axiWrite(pwrCtrlPkg::addrCtrl, 32'(newCtrl), pwrCtrlPkg::respOkay, randBelow(4));
    ctrlModel = newCtrl;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic resetValues;
    logic [31:0] data;
    // Three rising edges under reset, released on the falling edge after
    repeat (3) @(posedge pclk14);
    @(negedge pclk14);
    checkValue("rstnNonRet in reset", 0, rstnNonRet);
    nprst14 = 1'b1;
    @(negedge pclk14);
    checkValue("handshake outputs", 0, {awready, wready, bvalid, arready, rvalid});
    checkValue("saveEdge", 0, saveEdge);
    checkValue("restoreEdge", 0, restoreEdge);
    for (int d = 0; d < nd; d++)
      checkDomain(d, 1'b0);
    axiRead(pwrCtrlPkg::addrCtrl, pwrCtrlPkg::respOkay, 0, data);
    checkValue("ctrl after reset", 0, data);
    axiRead(pwrCtrlPkg::addrStatus, pwrCtrlPkg::respOkay, 0, data);
    checkValue("status after reset", 0, data);
  endtask

  task automatic domain0Down;
    writeRequest(nd'(1));
    pollStatus(nd'(1));
    waitDown(nd'(1));
    checkDomain(0, 1'b1);
    checkDomain(1, 1'b0);
    checkCounts();
  endtask

  task automatic domain0Up;
    logic [31:0] data;
    writeRequest('0);
    pollStatus('0);
    checkDomain(0, 1'b0);
    checkCounts();
    axiRead(pwrCtrlPkg::addrCtrl, pwrCtrlPkg::respOkay, 0, data);
    checkValue("ctrl readback", 32'(ctrlModel), data);
  endtask

  // Domains change in random order with random gaps between writes
  task automatic randomRounds;
    logic [nd-1:0] pattern;
    logic [nd-1:0] newCtrl;
    int first;
    int d;
    for (int r = 0; r < 5; r++)
    begin
      pattern = nd'($random(seed));
      first = randBelow(nd);
      for (int k = 0; k < nd; k++)
      begin
        d = (first + k) % nd;
        if (pattern[d] != ctrlModel[d])
        begin
          repeat (randBelow(8)) @(negedge pclk14);
          newCtrl = ctrlModel;
          newCtrl[d] = pattern[d];
          writeRequest(newCtrl);
        end
      end
      pollStatus(pattern);
      waitDown(pattern);
      for (int j = 0; j < nd; j++)
        checkDomain(j, pattern[j]);
      checkCounts();
    end
  endtask

  task automatic errorsAndStalls;
    logic [31:0] data;
    // Inverted request value, so any wrongly accepted write shows up
    axiWrite(pwrCtrlPkg::addrStatus, 32'(~ctrlModel), pwrCtrlPkg::respSlvErr, randBelow(8));
    axiWrite(4'h8, 32'(~ctrlModel), pwrCtrlPkg::respSlvErr, randBelow(8));
    axiRead(4'hC, pwrCtrlPkg::respSlvErr, randBelow(8), data);
    checkValue("unmapped rdata", 0, data);
    // Rejected writes leave both registers alone
    axiRead(pwrCtrlPkg::addrCtrl, pwrCtrlPkg::respOkay, 0, data);
    checkValue("ctrl after rejected writes", 32'(ctrlModel), data);
    axiRead(pwrCtrlPkg::addrStatus, pwrCtrlPkg::respOkay, 0, data);
    checkValue("status after rejected writes", 32'(ctrlModel), data);
    // Same request value again, so no sequence starts
    for (int i = 0; i < 3; i++)
    begin
      axiWrite(pwrCtrlPkg::addrCtrl, 32'(ctrlModel), pwrCtrlPkg::respOkay, randBelow(8));
      axiRead(pwrCtrlPkg::addrCtrl, pwrCtrlPkg::respOkay, randBelow(8), data);
      checkValue("ctrl under stall", 32'(ctrlModel), data);
      axiRead(pwrCtrlPkg::addrStatus, pwrCtrlPkg::respOkay, randBelow(8), data);
      checkValue("status under stall", 32'(ctrlModel), data);
    end
    checkCounts();
  endtask

  initial
  begin
    nprst14 = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    ctrlModel = '0;
    seed = 32'h2eb26463;
    for (int d = 0; d < nd; d++)
    begin
      expSave[d] = 0;
      expRestore[d] = 0;
      saveCnt[d] = 0;
      restoreCnt[d] = 0;
    end
    resetValues();
    domain0Down();
    domain0Up();
    randomRounds();
    errorsAndStalls();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verilog.f
logic/pwrCtrlPkg.sv
logic/pwrSeqFsm.sv
logic/pwrRegsAxil.sv
logic/pwrCtrlTop.sv
sim/pwrSeq_sva.sv
sim/pwrCtrlTb.sv

//--- Bender.yml
package:
  name: pwr_ctrl

dependencies: {}

sources:
  # RTL in compile order
  - logic/pwrCtrlPkg.sv
  - logic/pwrSeqFsm.sv
  - logic/pwrRegsAxil.sv
  - logic/pwrCtrlTop.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/pwrSeq_sva.sv
      - sim/pwrCtrlTb.sv
